// ==== verilog/itim_settings.svh ====
`ifndef ITIM_SETTINGS_SVH
`define ITIM_SETTINGS_SVH

// Set index bits, 16 sets by default
`define ITIM_DEPTH 4

// Word-in-line bits, 4 words per line by default
`define ITIM_WIDTH 2

// Window of byte addresses held by the ITIM, top address excluded
`define ITIM_BASE_ADDR 32'h0000_0000
`define ITIM_TOP_ADDR 32'h0000_4000

`endif

// ==== verilog/itim_pkg.sv ====
`default_nettype none

`include "itim_settings.svh"

package itim_pkg;

  typedef logic [31:0] addr_t; // Byte address
  typedef logic [31:0] word_t; // Instruction word

  typedef logic [`ITIM_DEPTH-1:0] index_t;
  typedef logic [`ITIM_WIDTH-1:0] offset_t;
  typedef logic [29-(`ITIM_DEPTH+`ITIM_WIDTH):0] tag_t;
  typedef logic [32*(2**`ITIM_WIDTH)-1:0] line_t;

  // Fetch request from the core, a fence when both valid and fence are set
  typedef struct packed {
    logic valid;
    logic fence;
    addr_t addr;
  } fetch_req_t;

  // Request to the backing bus, valid is held until the word completes
  typedef struct packed {
    logic valid;
    addr_t addr;
  } bus_req_t;

  // Shared by the fetch response and the bus response
  typedef struct packed {
    logic ready;
    word_t rdata;
  } mem_rsp_t;

  typedef enum logic [2:0] {
    hit,
    miss,
    load,
    update,
    fence
  } itim_state_t;

endpackage

`default_nettype wire

// ==== verilog/itim_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "itim_settings.svh"

module itim_array
  import itim_pkg::*;
#(
  parameter int entry_width = 1
) (
  input wire logic clock,
  input wire index_t read_index,
  input wire logic write,
  input wire index_t write_index,
  input wire logic [entry_width-1:0] wdata,
  output logic [entry_width-1:0] rdata
);

  logic [entry_width-1:0] entries [2**`ITIM_DEPTH] = '{default: '0};
  index_t read_index_q = '0;

  always_ff @(posedge clock) begin
    read_index_q <= read_index;
    if (write) begin
      entries[write_index] <= wdata;
    end
  end

  // Read through the registered index, so a write at the same edge is seen
  assign rdata = entries[read_index_q];

endmodule

`default_nettype wire

// ==== verilog/itim_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "itim_settings.svh"

module itim_ctrl
  import itim_pkg::*;
(
  input wire logic clock,
  input wire logic reset,
  input wire fetch_req_t fetch_req,
  output mem_rsp_t fetch_rsp,
  output bus_req_t bus_req,
  input wire mem_rsp_t bus_rsp,
  output index_t read_index,
  output index_t write_index,
  output logic line_write,
  output logic lock_write,
  output tag_t tag_wdata,
  output line_t line_wdata,
  output logic lock_wdata,
  input wire tag_t tag_rdata,
  input wire line_t line_rdata,
  input wire logic lock_rdata
);

  // Captured request, split into its address fields
  typedef struct packed {
    logic valid;
    logic fence;
    addr_t addr;
    tag_t tag;
    index_t index;
    offset_t offset;
  } front_t;

  typedef struct packed {
    itim_state_t state;
    logic bus_valid;
    addr_t bus_addr;
    offset_t count; // Word being filled
    index_t walk;   // Set being cleared by a fence
  } back_t;

  localparam back_t back_reset = '{state: hit, default: '0};

  front_t front_q;
  front_t front_d;
  back_t back_q;
  back_t back_d;
  line_t line_q;
  line_t line_next;
  logic in_window;

  always_comb begin
    front_d = front_q;
    front_d.valid = 1'b0;
    front_d.fence = 1'b0;
    if (fetch_req.valid && fetch_req.fence) begin
      front_d.fence = 1'b1;
    end else if (fetch_req.valid) begin
      front_d.valid = 1'b1;
      front_d.addr = fetch_req.addr;
      front_d.tag = fetch_req.addr[31:`ITIM_DEPTH+`ITIM_WIDTH+2];
      front_d.index = fetch_req.addr[`ITIM_DEPTH+`ITIM_WIDTH+1:`ITIM_WIDTH+2];
      front_d.offset = fetch_req.addr[`ITIM_WIDTH+1:2];
    end
  end

  // One unsigned compare covers both ends of the window
  assign in_window = (front_q.addr - `ITIM_BASE_ADDR) < (`ITIM_TOP_ADDR - `ITIM_BASE_ADDR);

  // Arrays are read at the edge that samples the request
  always_comb begin
    case (back_q.state)
      hit: read_index = front_d.index;
      fence: read_index = back_q.walk;
      default: read_index = front_q.index;
    endcase
  end

  always_comb begin
    line_next = line_q;
    if (back_q.state == miss && bus_rsp.ready) begin
      line_next[32*back_q.count +: 32] = bus_rsp.rdata; // Merge the completed word
    end
  end

  always_comb begin
    back_d = back_q;
    fetch_rsp = '0;
    write_index = front_q.index;
    line_write = 1'b0;
    lock_write = 1'b0;
    lock_wdata = 1'b0;

    case (back_q.state)
      hit: begin
        if (front_q.fence) begin
          back_d.state = fence;
          back_d.walk = '0;
        end else if (front_q.valid) begin
          if (!in_window) begin
            back_d.state = load;
            back_d.bus_valid = 1'b1;
            back_d.bus_addr = front_q.addr;
          end else if (!lock_rdata) begin
            // Free set, fetch the whole line from its first word
            back_d.state = miss;
            back_d.bus_valid = 1'b1;
            back_d.bus_addr = {front_q.addr[31:`ITIM_WIDTH+2], {(`ITIM_WIDTH+2){1'b0}}};
            back_d.count = '0;
          end else if (tag_rdata != front_q.tag) begin
            // Locked by another line, never replaced
            back_d.state = load;
            back_d.bus_valid = 1'b1;
            back_d.bus_addr = front_q.addr;
          end else begin
            fetch_rsp.ready = 1'b1;
            fetch_rsp.rdata = line_rdata[32*front_q.offset +: 32];
          end
        end
      end

      miss: begin
        if (bus_rsp.ready) begin
          if (back_q.count == '1) begin
            line_write = 1'b1;
            lock_write = 1'b1;
            lock_wdata = 1'b1;
            back_d.bus_valid = 1'b0;
            back_d.state = update;
          end else begin
            back_d.bus_addr = back_q.bus_addr + 32'd4;
            back_d.count = back_q.count + 1'b1;
          end
        end
      end

      load: begin
        fetch_rsp.ready = bus_rsp.ready; // Bus word goes straight to the core
        fetch_rsp.rdata = bus_rsp.rdata;
        if (bus_rsp.ready) begin
          back_d.bus_valid = 1'b0;
          back_d.state = hit;
        end
      end

      update: begin
        fetch_rsp.ready = 1'b1;
        fetch_rsp.rdata = line_q[32*front_q.offset +: 32];
        back_d.state = hit;
      end

      fence: begin
        write_index = back_q.walk;
        lock_write = 1'b1;
        if (back_q.walk == '1) begin
          fetch_rsp.ready = 1'b1; // Last set cleared at this edge
          back_d.state = hit;
        end else begin
          back_d.walk = back_q.walk + 1'b1;
        end
      end

      default: begin
        back_d.state = hit;
      end
    endcase
  end

  assign tag_wdata = front_q.tag;
  assign line_wdata = line_next;
  assign bus_req = '{valid: back_q.bus_valid, addr: back_q.bus_addr};

  always_ff @(posedge clock) begin
    if (reset) begin
      front_q <= '0;
      back_q <= back_reset;
    end else begin
      front_q <= front_d;
      back_q <= back_d;
    end
  end

  always_ff @(posedge clock) begin
    line_q <= line_next;
  end

endmodule

`default_nettype wire

// ==== verilog/itim.sv ====
`timescale 1ns/1ps
`default_nettype none

module itim
  import itim_pkg::*;
(
  input wire logic clock,
  input wire logic reset,
  input wire fetch_req_t fetch_req,
  output mem_rsp_t fetch_rsp,
  output bus_req_t bus_req,
  input wire mem_rsp_t bus_rsp
);

  index_t read_index;
  index_t write_index;
  logic line_write;
  logic lock_write;
  tag_t tag_wdata;
  tag_t tag_rdata;
  line_t line_wdata;
  line_t line_rdata;
  logic lock_wdata;
  logic lock_rdata;

  itim_ctrl i_itim_ctrl (
    .clock(clock),
    .reset(reset),
    .fetch_req(fetch_req),
    .fetch_rsp(fetch_rsp),
    .bus_req(bus_req),
    .bus_rsp(bus_rsp),
    .read_index(read_index),
    .write_index(write_index),
    .line_write(line_write),
    .lock_write(lock_write),
    .tag_wdata(tag_wdata),
    .line_wdata(line_wdata),
    .lock_wdata(lock_wdata),
    .tag_rdata(tag_rdata),
    .line_rdata(line_rdata),
    .lock_rdata(lock_rdata)
  );

  // Tag and line are written together when a fill completes
  itim_array #(.entry_width($bits(tag_t))) tag_array (
    .clock(clock),
    .read_index(read_index),
    .write(line_write),
    .write_index(write_index),
    .wdata(tag_wdata),
    .rdata(tag_rdata)
  );

  itim_array #(.entry_width($bits(line_t))) line_array (
    .clock(clock),
    .read_index(read_index),
    .write(line_write),
    .write_index(write_index),
    .wdata(line_wdata),
    .rdata(line_rdata)
  );

  itim_array #(.entry_width(1)) lock_array (
    .clock(clock),
    .read_index(read_index),
    .write(lock_write),
    .write_index(write_index),
    .wdata(lock_wdata),
    .rdata(lock_rdata)
  );

endmodule

`default_nettype wire

// ==== verification/itim_bus_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module itim_bus_model
  import itim_pkg::*;
#(
  parameter int seed = 97929
) (
  input wire logic clock,
  input wire logic reset,
  input wire bus_req_t bus_req,
  input wire word_t generation,
  output mem_rsp_t bus_rsp
);

  logic active;
  int unsigned delay;

  initial begin
    void'($urandom(seed));
  end

  // Each word is answered 1 to 4 edges after the model first sees the request
  always @(posedge clock) begin
    if (reset) begin
      bus_rsp <= '0;
      active <= 1'b0;
      delay <= 0;
    end else begin
      bus_rsp.ready <= 1'b0;
      if (bus_req.valid && !bus_rsp.ready) begin
        if (!active) begin
          active <= 1'b1;
          delay <= $urandom % 4;
        end else if (delay == 0) begin
          bus_rsp.ready <= 1'b1;
          bus_rsp.rdata <= bus_req.addr ^ (generation * 32'h0101_0101);
          active <= 1'b0;
        end else begin
          delay <= delay - 1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/itim_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "itim_settings.svh"

module itim_tb
  import itim_pkg::*;
();

  localparam int line_words = 2**`ITIM_WIDTH;
  localparam int sets = 2**`ITIM_DEPTH;
  localparam int line_bytes = 4 * line_words;
  localparam addr_t cached_addr = `ITIM_BASE_ADDR + addr_t'(line_bytes * sets) + 32'd8;
  localparam addr_t conflict_addr = cached_addr + addr_t'(line_bytes * sets); // Same set
  localparam addr_t outside_addr = `ITIM_TOP_ADDR + 32'h40;
  localparam addr_t refill_addr = cached_addr + addr_t'(3 * line_bytes);
  localparam int fetch_count = 16;
  localparam int fill_cycles = line_words * 6 + 8;
  localparam int timeout_cycles = 2 * (fetch_count * fill_cycles + sets + 8) + 40;

  logic clock;
  logic reset;
  fetch_req_t fetch_req;
  mem_rsp_t fetch_rsp;
  bus_req_t bus_req;
  mem_rsp_t bus_rsp;
  word_t generation;
  int words_total = 0;
  addr_t bus_addr_log [256];
  string test_name;
  int test_count = 0;
  int failed_tests = 0;
  int check_count = 0;
  int error_count = 0;
  int test_errors = 0;
  int property_errors = 0;
  int property_start = 0;

  itim i_itim (
    .clock(clock),
    .reset(reset),
    .fetch_req(fetch_req),
    .fetch_rsp(fetch_rsp),
    .bus_req(bus_req),
    .bus_rsp(bus_rsp)
  );

  itim_bus_model #(.seed(97929)) i_itim_bus_model (
    .clock(clock),
    .reset(reset),
    .bus_req(bus_req),
    .generation(generation),
    .bus_rsp(bus_rsp)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  initial begin
    #(timeout_cycles * 8);
    $display("watchdog expired before all tests finished");
    $display("TEST FAILED");
    $finish;
  end

  always @(negedge clock) begin
    if (!reset && bus_req.valid && bus_rsp.ready) begin
      bus_addr_log[words_total % 256] <= bus_req.addr; // One entry per completed word
      words_total <= words_total + 1;
    end
  end

  assert property (@(posedge clock) disable iff (reset)
      bus_req.valid && !bus_rsp.ready |=> bus_req.valid && $stable(bus_req.addr))
    else begin
      property_errors = property_errors + 1;
      $display("bus request dropped or changed its address before ready");
    end

  // A fill steps by one word, a bypass drops valid after its word
  assert property (@(posedge clock) disable iff (reset)
      bus_req.valid && bus_rsp.ready |=>
      !bus_req.valid || bus_req.addr == $past(bus_req.addr) + 32'd4)
    else begin
      property_errors = property_errors + 1;
      $display("bus address did not advance by one word during a line fill");
    end

  assert property (@(posedge clock) disable iff (reset) fetch_rsp.ready |=> !fetch_rsp.ready)
    else begin
      property_errors = property_errors + 1;
      $display("fetch response ready lasted longer than one cycle");
    end

  assert property (@(posedge clock) reset |=> !fetch_rsp.ready && !bus_req.valid)
    else begin
      property_errors = property_errors + 1;
      $display("fetch ready or bus valid was high right after reset");
    end

  function automatic word_t expected_word(input addr_t addr, input word_t gen);
    return addr ^ (gen * 32'h0101_0101);
  endfunction

  task automatic check_equal(input string what, input logic [31:0] expected,
      input logic [31:0] actual);
    check_count++;
    assert (actual == expected)
      else begin
        error_count++;
        test_errors++;
        $display("error %s %s: expected %h actual %h", test_name, what, expected, actual);
      end
  endtask

  task automatic check_at_least(input string what, input int minimum, input int actual);
    check_count++;
    assert (actual >= minimum)
      else begin
        error_count++;
        test_errors++;
        $display("error %s %s: expected at least %0d actual %0d", test_name, what, minimum,
          actual);
      end
  endtask

  task automatic issue_request(input logic fence_req, input addr_t addr, output word_t data,
      output int latency, output int start);
    start = words_total;
    latency = 0;
    @(posedge clock);
    fetch_req <= '{valid: 1'b1, fence: fence_req, addr: addr};
    @(posedge clock);
    fetch_req <= '{valid: 1'b0, fence: 1'b0, addr: addr}; // Request sampled at this edge
    do begin
      @(negedge clock);
      latency++;
    end while (!fetch_rsp.ready);
    data = fetch_rsp.rdata;
    @(posedge clock);
  endtask

  task automatic fetch_check(input addr_t addr, input word_t gen, input int expected_words);
    word_t data;
    int latency;
    int start;
    addr_t first;
    issue_request(1'b0, addr, data, latency, start);
    first = (expected_words == 1) ? addr : addr & ~(addr_t'(line_bytes) - 32'd1);
    check_equal("rdata", expected_word(addr, gen), data);
    check_equal("bus words", expected_words, words_total - start);
    for (int i = 0; i < expected_words; i++) begin
      check_equal("bus address", first + addr_t'(4 * i), bus_addr_log[(start + i) % 256]);
    end
    if (expected_words == 0) begin
      check_equal("hit latency", 1, latency);
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errors = 0;
    property_start = property_errors;
    test_count++;
  endtask

  task automatic end_test();
    if (test_errors > 0 || property_errors != property_start) begin
      failed_tests++;
      $display("%s failed", test_name);
    end else begin
      $display("%s passed", test_name);
    end
  endtask

  initial begin
    word_t data;
    int latency;
    int start;
    fetch_req <= '0;
    reset <= 1'b1;
    generation <= 32'd1;
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    @(posedge clock);

    begin_test("first_fetch");
    fetch_check(cached_addr, 32'd1, line_words);
    end_test();

    begin_test("same_line");
    fetch_check(cached_addr, 32'd1, 0);
    fetch_check(cached_addr - 32'd8, 32'd1, 0);
    fetch_check(cached_addr + 32'd4, 32'd1, 0);
    fetch_check(cached_addr - 32'd4, 32'd1, 0);
    end_test();

    begin_test("generation_change");
    generation <= 32'd2;
    fetch_check(cached_addr, 32'd1, 0);
    fetch_check(outside_addr, 32'd2, 1);
    fetch_check(outside_addr + 32'd4, 32'd2, 1);
    end_test();

    begin_test("locked_conflict");
    fetch_check(conflict_addr, 32'd2, 1);
    fetch_check(cached_addr, 32'd1, 0);
    end_test();

    begin_test("fence");
    issue_request(1'b1, '0, data, latency, start);
    check_equal("fence rdata", 32'd0, data);
    check_at_least("fence latency", sets, latency);
    check_equal("fence bus words", 32'd0, words_total - start);
    fetch_check(cached_addr, 32'd2, line_words);
    end_test();

    // Reset lands in the middle of a line fill
    begin_test("reset_state");
    @(posedge clock);
    fetch_req <= '{valid: 1'b1, fence: 1'b0, addr: refill_addr};
    @(posedge clock);
    fetch_req <= '{valid: 1'b0, fence: 1'b0, addr: refill_addr};
    do begin
      @(negedge clock);
    end while (!bus_req.valid);
    @(posedge clock);
    reset <= 1'b1;
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    check_equal("ready after reset", 32'd0, 32'(fetch_rsp.ready));
    check_equal("bus valid after reset", 32'd0, 32'(bus_req.valid));
    @(posedge clock);
    fetch_check(refill_addr, 32'd2, line_words);
    end_test();

    $display("tests %0d, failed %0d, checks %0d, errors %0d", test_count, failed_tests,
      check_count, error_count + property_errors);
    if (error_count == 0 && property_errors == 0 && failed_tests == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+verilog
verilog/itim_pkg.sv
verilog/itim_array.sv
verilog/itim_ctrl.sv
verilog/itim.sv
verification/itim_bus_model.sv
verification/itim_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= itim_tb
RTL_TOP ?= itim
FILELIST ?= tb.f
RTL_SOURCES ?= verilog/itim_pkg.sv verilog/itim_array.sv verilog/itim_ctrl.sv verilog/itim.sv
INCDIR ?= verilog
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) +incdir+$(INCDIR) $(RTL_SOURCES) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
